// File: common/sigma_bus_pkg.sv
package sigma_bus_pkg;

    // host bus geometry
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // address bit that steers a request to the SFR block
    localparam int SFR_BITSEL = 20;

    // data RAM size in words
    localparam int RAM_AW    = 10;
    localparam int RAM_WORDS = 2 ** RAM_AW;

endpackage

// File: common/sigma_sfr_pkg.sv
package sigma_sfr_pkg;

    // interrupt line count
    localparam int IRQ_NUM_POW = 4;
    localparam int IRQ_NUM     = 2 ** IRQ_NUM_POW;

    // timer interrupt shares this external line
    localparam int TIMER_IRQ_LINE = 1;

    // low address bits decoded inside the SFR window
    localparam int SFR_AW = 8;

    // SFR byte offsets
    typedef enum logic [SFR_AW-1:0] {
        SFR_CORENUM      = 8'h00,
        SFR_CTRL         = 8'h04,
        SFR_IRQ_EN       = 8'h08,
        SFR_TIMER_PERIOD = 8'h0C,
        SFR_TIMER_VALUE  = 8'h10,
        SFR_SGI          = 8'h14
    } sfr_addr_e;

    // CTRL register bits
    localparam int CTRL_SW_RESET = 0;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
(
    input  logic                             clk_i
    , input  logic                           reset_i

    , input  logic                           host_req_i
    , input  logic                           host_we_i
    , input  logic [sigma_bus_pkg::ADDR_W-1:0] host_addr_i
    , output logic                           host_ack_o
    , output logic                           host_resp_o
    , output logic [sigma_bus_pkg::DATA_W-1:0] host_rdata_o

    , output logic                           ram_req_o
    , input  logic                           ram_resp_i
    , input  logic [sigma_bus_pkg::DATA_W-1:0] ram_rdata_i

    , output logic                           sfr_req_o
    , input  logic                           sfr_resp_i
    , input  logic [sigma_bus_pkg::DATA_W-1:0] sfr_rdata_i
);

    import sigma_bus_pkg::*;

    logic sel_sfr;
    logic rd_sfr_q;

    assign sel_sfr = host_addr_i[SFR_BITSEL];

    // single master, both targets always ready
    assign host_ack_o = host_req_i;

    assign ram_req_o = host_req_i & ~sel_sfr;
    assign sfr_req_o = host_req_i & sel_sfr;

    // remember where the last read went
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            rd_sfr_q <= 1'b0;
        end
        else if (host_req_i && !host_we_i)
        begin
            rd_sfr_q <= sel_sfr;
        end
    end

    assign host_resp_o  = ram_resp_i | sfr_resp_i;
    assign host_rdata_o = rd_sfr_q ? sfr_rdata_i : ram_rdata_i;

    // one read outstanding per cycle, so targets never answer together
    resp_exclusive_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(ram_resp_i && sfr_resp_i)
    ) else $error("RAM and SFR responded in the same cycle");

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps

module data_ram
(
    input  logic                             clk_i
    , input  logic                           reset_i

    , input  logic                           req_i
    , input  logic                           we_i
    , input  logic [sigma_bus_pkg::ADDR_W-1:0] addr_i
    , input  logic [sigma_bus_pkg::BE_W-1:0]   be_i
    , input  logic [sigma_bus_pkg::DATA_W-1:0] wdata_i

    , output logic                           resp_o
    , output logic [sigma_bus_pkg::DATA_W-1:0] rdata_o
);

    import sigma_bus_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] word_addr;

    // upper bits ignored, so the array aliases across the window
    assign word_addr = addr_i[RAM_AW+1:2];

    // memory powers up cleared
    initial
    begin
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (be_i[b])
                begin
                    mem[word_addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && !we_i)
        begin
            rdata_o <= mem[word_addr];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            resp_o <= 1'b0;
        end
        else
        begin
            resp_o <= req_i & ~we_i;
        end
    end

endmodule

// File: sfr/sfr.sv
`timescale 1ns/1ps

module sfr
#(
    parameter int core_num_p           = 0
    , parameter bit sw_reset_default_p = 1'b0
)
(
    input  logic                             clk_i
    , input  logic                           reset_i

    , input  logic                           req_i
    , input  logic                           we_i
    , input  logic [sigma_bus_pkg::ADDR_W-1:0] addr_i
    , input  logic [sigma_bus_pkg::DATA_W-1:0] wdata_i
    , output logic                           resp_o
    , output logic [sigma_bus_pkg::DATA_W-1:0] rdata_o

    , input  logic                           sw_reset_enb_i
    , input  logic                           sw_reset_set_i
    , input  logic                           sw_reset_autoclr_i
    , output logic                           core_reset_o

    , output logic [sigma_sfr_pkg::IRQ_NUM-1:0]     irq_en_o
    , output logic                                  irq_timer_o
    , output logic                                  sgi_req_o
    , output logic [sigma_sfr_pkg::IRQ_NUM_POW-1:0] sgi_code_o
);

    import sigma_bus_pkg::*;
    import sigma_sfr_pkg::*;

    logic              in_window;
    logic              wr;
    logic              ctrl_wr;
    logic              period_wr;
    logic              sgi_wr;
    logic              timer_wrap;
    logic              sw_reset_q;
    logic [DATA_W-1:0] period_q;
    logic [DATA_W-1:0] value_q;
    logic [DATA_W-1:0] rd_word;

    // offsets beyond the decoded low bits are unmapped
    assign in_window = (addr_i[SFR_BITSEL-1:SFR_AW] == '0);
    assign wr        = req_i & we_i & in_window;
    assign ctrl_wr   = wr && (addr_i[SFR_AW-1:0] == SFR_CTRL);
    assign period_wr = wr && (addr_i[SFR_AW-1:0] == SFR_TIMER_PERIOD);
    assign sgi_wr    = wr && (addr_i[SFR_AW-1:0] == SFR_SGI);

    always_comb
    begin
        rd_word = '0;
        if (in_window)
        begin
            case (addr_i[SFR_AW-1:0])
                SFR_CORENUM:      rd_word = DATA_W'(core_num_p);
                SFR_CTRL:         rd_word[CTRL_SW_RESET] = sw_reset_q;
                SFR_IRQ_EN:       rd_word[IRQ_NUM-1:0] = irq_en_o;
                SFR_TIMER_PERIOD: rd_word = period_q;
                SFR_TIMER_VALUE:  rd_word = value_q;
                default:          rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && !we_i)
        begin
            rdata_o <= rd_word;
        end
    end

    // software core reset
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            sw_reset_q <= sw_reset_default_p;
        end
        else if (ctrl_wr)
        begin
            sw_reset_q <= wdata_i[CTRL_SW_RESET];
        end
        else if (sw_reset_enb_i && sw_reset_set_i)
        begin
            sw_reset_q <= 1'b1;
        end
        else if (sw_reset_autoclr_i && sw_reset_q)
        begin
            sw_reset_q <= 1'b0;
        end
    end

    assign core_reset_o = reset_i | sw_reset_q;

    assign timer_wrap = (period_q != '0) && (value_q == period_q - 1'b1);

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            resp_o      <= 1'b0;
            irq_en_o    <= '0;
            period_q    <= '0;
            value_q     <= '0;
            irq_timer_o <= 1'b0;
            sgi_req_o   <= 1'b0;
        end
        else
        begin
            resp_o      <= req_i & ~we_i;
            sgi_req_o   <= sgi_wr;
            irq_timer_o <= timer_wrap & ~period_wr;
            if (wr && (addr_i[SFR_AW-1:0] == SFR_IRQ_EN))
            begin
                irq_en_o <= wdata_i[IRQ_NUM-1:0];
            end
            // new period restarts the count
            if (period_wr)
            begin
                period_q <= wdata_i;
                value_q  <= '0;
            end
            else if (timer_wrap)
            begin
                value_q <= '0;
            end
            else if (period_q != '0)
            begin
                value_q <= value_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (sgi_wr)
        begin
            sgi_code_o <= wdata_i[IRQ_NUM_POW-1:0];
        end
    end

    // strobe drops unless another SGI write follows
    sgi_one_cycle_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (sgi_req_o && !sgi_wr) |=> !sgi_req_o
    ) else $error("sgi_req_o held longer than one cycle");

endmodule

// File: sfr/irq_adapter.sv
`timescale 1ns/1ps

module irq_adapter
(
    input  logic                                    clk_i
    , input  logic                                  reset_i

    , input  logic [sigma_sfr_pkg::IRQ_NUM-1:0]     irq_lines_i
    , input  logic [sigma_sfr_pkg::IRQ_NUM-1:0]     irq_en_i
    , input  logic                                  irq_timer_i
    , input  logic                                  sgi_req_i
    , input  logic [sigma_sfr_pkg::IRQ_NUM_POW-1:0] sgi_code_i

    , output logic                                  irq_req_o
    , output logic [sigma_sfr_pkg::IRQ_NUM_POW-1:0] irq_code_o
    , input  logic                                  irq_ack_i
);

    import sigma_sfr_pkg::*;

    logic [IRQ_NUM-1:0]     lines_eff;
    logic [IRQ_NUM-1:0]     lines_q;
    logic [IRQ_NUM-1:0]     pending_q;
    logic [IRQ_NUM-1:0]     set_vec;
    logic [IRQ_NUM-1:0]     clr_vec;
    logic [IRQ_NUM_POW-1:0] lowest;
    logic [IRQ_NUM_POW-1:0] code_q;
    logic                   held_q;
    logic                   taken;

    // timer shares its line with the external input
    assign lines_eff = (irq_lines_i | (IRQ_NUM'(irq_timer_i) << TIMER_IRQ_LINE)) & irq_en_i;

    always_comb
    begin
        set_vec = lines_eff & ~lines_q;
        if (sgi_req_i)
        begin
            set_vec[sgi_code_i] = 1'b1;
        end
    end

    // scan downwards so the lowest index wins
    always_comb
    begin
        lowest = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (pending_q[i])
            begin
                lowest = IRQ_NUM_POW'(i);
            end
        end
    end

    assign irq_req_o  = |pending_q;
    assign irq_code_o = held_q ? code_q : lowest;
    assign taken      = irq_req_o & irq_ack_i;

    always_comb
    begin
        clr_vec = '0;
        if (taken)
        begin
            clr_vec[irq_code_o] = 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            lines_q   <= '0;
            pending_q <= '0;
            held_q    <= 1'b0;
            code_q    <= '0;
        end
        else
        begin
            lines_q   <= lines_eff;
            pending_q <= (pending_q & ~clr_vec) | set_vec;
            // freeze the offered code until the core takes it
            held_q    <= irq_req_o & ~irq_ack_i;
            code_q    <= irq_code_o;
        end
    end

    code_stable_a : assert property (
        @(posedge clk_i) disable iff (reset_i)
        (irq_req_o && !irq_ack_i) |=> $stable(irq_code_o)
    ) else $error("irq_code_o changed before acknowledge");

endmodule

// File: logic/sigma_tile.sv
`timescale 1ns/1ps

module sigma_tile
#(
    parameter int core_num_p           = 0
    , parameter bit sw_reset_default_p = 1'b0
)
(
    input  logic                             clk_i
    , input  logic                           reset_i

    // host bus
    , input  logic                           host_req_i
    , input  logic                           host_we_i
    , input  logic [sigma_bus_pkg::ADDR_W-1:0] host_addr_i
    , input  logic [sigma_bus_pkg::BE_W-1:0]   host_be_i
    , input  logic [sigma_bus_pkg::DATA_W-1:0] host_wdata_i
    , output logic                           host_ack_o
    , output logic                           host_resp_o
    , output logic [sigma_bus_pkg::DATA_W-1:0] host_rdata_o

    , input  logic                           sw_reset_enb_i
    , input  logic                           sw_reset_set_i
    , input  logic                           sw_reset_autoclr_i
    , output logic                           core_reset_o

    , input  logic [sigma_sfr_pkg::IRQ_NUM-1:0]     irq_lines_i
    , output logic                                  irq_req_o
    , output logic [sigma_sfr_pkg::IRQ_NUM_POW-1:0] irq_code_o
    , input  logic                                  irq_ack_i
);

    import sigma_bus_pkg::*;
    import sigma_sfr_pkg::*;

    logic              ram_req;
    logic              ram_resp;
    logic [DATA_W-1:0] ram_rdata;
    logic              sfr_req;
    logic              sfr_resp;
    logic [DATA_W-1:0] sfr_rdata;

    logic [IRQ_NUM-1:0]     irq_en;
    logic                   irq_timer;
    logic                   sgi_req;
    logic [IRQ_NUM_POW-1:0] sgi_code;

    bus_decoder i_decoder (
        .clk_i          (clk_i)
        , .reset_i      (reset_i)
        , .host_req_i   (host_req_i)
        , .host_we_i    (host_we_i)
        , .host_addr_i  (host_addr_i)
        , .host_ack_o   (host_ack_o)
        , .host_resp_o  (host_resp_o)
        , .host_rdata_o (host_rdata_o)
        , .ram_req_o    (ram_req)
        , .ram_resp_i   (ram_resp)
        , .ram_rdata_i  (ram_rdata)
        , .sfr_req_o    (sfr_req)
        , .sfr_resp_i   (sfr_resp)
        , .sfr_rdata_i  (sfr_rdata)
    );

    data_ram i_ram (
        .clk_i     (clk_i)
        , .reset_i (reset_i)
        , .req_i   (ram_req)
        , .we_i    (host_we_i)
        , .addr_i  (host_addr_i)
        , .be_i    (host_be_i)
        , .wdata_i (host_wdata_i)
        , .resp_o  (ram_resp)
        , .rdata_o (ram_rdata)
    );

    sfr #(
        .core_num_p           (core_num_p)
        , .sw_reset_default_p (sw_reset_default_p)
    ) i_sfr (
        .clk_i                (clk_i)
        , .reset_i            (reset_i)
        , .req_i              (sfr_req)
        , .we_i               (host_we_i)
        , .addr_i             (host_addr_i)
        , .wdata_i            (host_wdata_i)
        , .resp_o             (sfr_resp)
        , .rdata_o            (sfr_rdata)
        , .sw_reset_enb_i     (sw_reset_enb_i)
        , .sw_reset_set_i     (sw_reset_set_i)
        , .sw_reset_autoclr_i (sw_reset_autoclr_i)
        , .core_reset_o       (core_reset_o)
        , .irq_en_o           (irq_en)
        , .irq_timer_o        (irq_timer)
        , .sgi_req_o          (sgi_req)
        , .sgi_code_o         (sgi_code)
    );

    // interrupt state follows the core reset
    irq_adapter i_irq (
        .clk_i         (clk_i)
        , .reset_i     (core_reset_o)
        , .irq_lines_i (irq_lines_i)
        , .irq_en_i    (irq_en)
        , .irq_timer_i (irq_timer)
        , .sgi_req_i   (sgi_req)
        , .sgi_code_i  (sgi_code)
        , .irq_req_o   (irq_req_o)
        , .irq_code_o  (irq_code_o)
        , .irq_ack_i   (irq_ack_i)
    );

endmodule

// File: tb/tb_tile_model.svh
`ifndef TB_TILE_MODEL_SVH
`define TB_TILE_MODEL_SVH

// RAM image keyed by word index, missing words read as zero
logic [31:0]        model_mem [int];
logic [IRQ_NUM-1:0] model_irq_en;
logic [31:0]        model_period;
logic               model_sw_reset;
logic [IRQ_NUM-1:0] model_pending;
logic [IRQ_NUM-1:0] model_lines_q;

function automatic int model_word(input logic [31:0] addr);
    return int'(addr[RAM_AW+1:2]);
endfunction

function automatic logic [31:0] model_ram_read(input logic [31:0] addr);
    if (model_mem.exists(model_word(addr)))
    begin
        return model_mem[model_word(addr)];
    end
    return '0;
endfunction

function automatic void model_ram_write(input logic [31:0] addr, input logic [3:0] be,
                                        input logic [31:0] data);
    logic [31:0] word;
    word = model_ram_read(addr);
    for (int b = 0; b < 4; b++)
    begin
        if (be[b])
        begin
            word[b*8 +: 8] = data[b*8 +: 8];
        end
    end
    model_mem[model_word(addr)] = word;
endfunction

// offset within the SFR window
function automatic logic [31:0] model_sfr_read(input logic [19:0] offset);
    case (offset)
        20'h00:  return CORE_NUM;
        20'h04:  return {31'b0, model_sw_reset};
        20'h08:  return {{(32-IRQ_NUM){1'b0}}, model_irq_en};
        20'h0C:  return model_period;
        default: return '0;
    endcase
endfunction

// rising edges of enabled lines become pending
function automatic void model_line_update(input logic [IRQ_NUM-1:0] lines);
    logic [IRQ_NUM-1:0] eff;
    eff           = lines & model_irq_en;
    model_pending = model_pending | (eff & ~model_lines_q);
    model_lines_q = eff;
endfunction

function automatic int model_lowest();
    for (int i = 0; i < IRQ_NUM; i++)
    begin
        if (model_pending[i])
        begin
            return i;
        end
    end
    return 0;
endfunction

function automatic void model_irq_clear();
    model_pending = '0;
    model_lines_q = '0;
endfunction

`endif

// File: tb/tb_sigma_tile.sv
`timescale 1ns/1ps

module tb_sigma_tile;

    import sigma_bus_pkg::*;
    import sigma_sfr_pkg::*;

    localparam int          CORE_NUM = 5;
    localparam int          TIMEOUT  = 64;
    localparam logic [31:0] SFR_BASE = 32'h1 << SFR_BITSEL;

    logic                   clk_i;
    logic                   reset_i;
    logic                   host_req_i;
    logic                   host_we_i;
    logic [ADDR_W-1:0]      host_addr_i;
    logic [BE_W-1:0]        host_be_i;
    logic [DATA_W-1:0]      host_wdata_i;
    logic                   host_ack_o;
    logic                   host_resp_o;
    logic [DATA_W-1:0]      host_rdata_o;
    logic                   sw_reset_enb_i;
    logic                   sw_reset_set_i;
    logic                   sw_reset_autoclr_i;
    logic                   core_reset_o;
    logic [IRQ_NUM-1:0]     irq_lines_i;
    logic                   irq_req_o;
    logic [IRQ_NUM_POW-1:0] irq_code_o;
    logic                   irq_ack_i;

    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    logic [31:0] burst_addr [8];
    logic [31:0] burst_exp [8];
    logic [31:0] wr_addr [32];

    `include "tb_tile_model.svh"

    sigma_tile #(
        .core_num_p           (CORE_NUM)
        , .sw_reset_default_p (1'b0)
    ) i_dut (
        .clk_i                (clk_i)
        , .reset_i            (reset_i)
        , .host_req_i         (host_req_i)
        , .host_we_i          (host_we_i)
        , .host_addr_i        (host_addr_i)
        , .host_be_i          (host_be_i)
        , .host_wdata_i       (host_wdata_i)
        , .host_ack_o         (host_ack_o)
        , .host_resp_o        (host_resp_o)
        , .host_rdata_o       (host_rdata_o)
        , .sw_reset_enb_i     (sw_reset_enb_i)
        , .sw_reset_set_i     (sw_reset_set_i)
        , .sw_reset_autoclr_i (sw_reset_autoclr_i)
        , .core_reset_o       (core_reset_o)
        , .irq_lines_i        (irq_lines_i)
        , .irq_req_o          (irq_req_o)
        , .irq_code_o         (irq_code_o)
        , .irq_ack_i          (irq_ack_i)
    );

    always #4 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // random bits 19:12 exercise aliasing above the RAM depth
    function automatic logic [31:0] rand_ram_addr();
        logic [7:0]        hi;
        logic [RAM_AW-1:0] word;
        hi   = 8'(take_bits(8));
        word = RAM_AW'(take_bits(RAM_AW));
        return {12'h000, hi, word, 2'b00};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // holds the request across one accepting edge
    task automatic drive(input logic we, input logic [31:0] addr, input logic [3:0] be,
                         input logic [31:0] data);
        host_req_i   = 1'b1;
        host_we_i    = we;
        host_addr_i  = addr;
        host_be_i    = be;
        host_wdata_i = data;
        @(posedge clk_i);
        check("host_ack", 1, host_ack_o);
        @(negedge clk_i);
    endtask

    task automatic idle();
        host_req_i = 1'b0;
        host_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        drive(1'b1, addr, be, data);
        idle();
    endtask

    task automatic bus_read(input string name, input logic [31:0] addr,
                            input logic [31:0] expected);
        int lat;
        drive(1'b0, addr, 4'hf, '0);
        idle();
        lat = 1;
        while (!host_resp_o && lat < TIMEOUT)
        begin
            @(negedge clk_i);
            lat++;
        end
        if (!host_resp_o)
        begin
            errors++;
            $display("timeout: no read response for %s at address %h", name, addr);
        end
        else
        begin
            check("read latency", 1, lat);
            check(name, expected, host_rdata_o);
        end
    endtask

    // each response must show up while the next read is being accepted
    task automatic burst_read(input string name, input int n);
        for (int i = 0; i < n; i++)
        begin
            drive(1'b0, burst_addr[i], 4'hf, '0);
            check("burst resp", 1, host_resp_o);
            check(name, burst_exp[i], host_rdata_o);
        end
        idle();
        @(negedge clk_i);
        check("burst resp end", 0, host_resp_o);
    endtask

    task automatic wait_irq(input string name, input int limit);
        int n;
        n = 0;
        while (!irq_req_o && n < limit)
        begin
            @(negedge clk_i);
            n++;
        end
        if (!irq_req_o)
        begin
            errors++;
            $display("timeout: %s raised no interrupt request in %0d cycles", name, limit);
        end
    endtask

    task automatic take_irq(input string name);
        int low;
        low = model_lowest();
        check(name, low, irq_code_o);
        irq_ack_i = 1'b1;
        @(negedge clk_i);
        irq_ack_i = 1'b0;
        model_pending[low] = 1'b0;
    endtask

    initial
    begin
        logic [3:0]             be;
        logic [31:0]            data;
        logic [IRQ_NUM-1:0]     lines;
        logic [IRQ_NUM_POW-1:0] code;

        clk_i              = 1'b0;
        reset_i            = 1'b1;
        host_req_i         = 1'b0;
        host_we_i          = 1'b0;
        host_addr_i        = '0;
        host_be_i          = '0;
        host_wdata_i       = '0;
        sw_reset_enb_i     = 1'b0;
        sw_reset_set_i     = 1'b0;
        sw_reset_autoclr_i = 1'b0;
        irq_lines_i        = '0;
        irq_ack_i          = 1'b0;
        lfsr_q             = 32'hc4909828;
        errors             = 0;
        checks             = 0;
        model_irq_en       = '0;
        model_period       = '0;
        model_sw_reset     = 1'b0;
        model_irq_clear();

        repeat (2) @(negedge clk_i);
        check("core_reset in reset", 1, core_reset_o);
        reset_i = 1'b0;
        @(negedge clk_i);
        check("core_reset after reset", 0, core_reset_o);
        check("resp after reset", 0, host_resp_o);
        check("irq_req after reset", 0, irq_req_o);

        // RAM writes with random byte enables, then single and burst reads
        for (int i = 0; i < 32; i++)
        begin
            wr_addr[i] = rand_ram_addr();
            be         = 4'(take_bits(4));
            data       = take_bits(32);
            model_ram_write(wr_addr[i], be, data);
            bus_write(wr_addr[i], be, data);
        end
        for (int i = 0; i < 16; i++)
        begin
            bus_read("ram read", wr_addr[i], model_ram_read(wr_addr[i]));
        end
        for (int j = 0; j < 2; j++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                burst_addr[k] = wr_addr[16 + 8*j + k];
                burst_exp[k]  = model_ram_read(burst_addr[k]);
            end
            burst_read("ram burst", 8);
        end

        // RAM and SFR interleaved
        for (int k = 0; k < 8; k++)
        begin
            if (k % 2 == 1)
            begin
                burst_addr[k] = SFR_BASE | ((k % 4 == 1) ? SFR_CORENUM : SFR_IRQ_EN);
                burst_exp[k]  = model_sfr_read(burst_addr[k][19:0]);
            end
            else
            begin
                burst_addr[k] = wr_addr[k];
                burst_exp[k]  = model_ram_read(burst_addr[k]);
            end
        end
        burst_read("mixed burst", 8);
        bus_read("corenum", SFR_BASE | SFR_CORENUM, model_sfr_read(20'h00));

        // SFR readback and unmapped offsets
        data = take_bits(32);
        bus_write(SFR_BASE | SFR_IRQ_EN, 4'hf, data);
        model_irq_en = data[IRQ_NUM-1:0];
        bus_read("irq_en", SFR_BASE | SFR_IRQ_EN, model_sfr_read(20'h08));
        data = take_bits(32);
        bus_write(SFR_BASE | SFR_TIMER_PERIOD, 4'hf, data);
        model_period = data;
        bus_read("timer period", SFR_BASE | SFR_TIMER_PERIOD, model_sfr_read(20'h0C));
        bus_write(SFR_BASE | 32'h18, 4'hf, take_bits(32));
        bus_read("unmapped 0x18", SFR_BASE | 32'h18, model_sfr_read(20'h18));
        bus_read("unmapped 0x40", SFR_BASE | 32'h40, model_sfr_read(20'h40));
        bus_read("unmapped 0x100", SFR_BASE | 32'h100, model_sfr_read(20'h100));
        bus_write(SFR_BASE | SFR_TIMER_PERIOD, 4'hf, '0);
        model_period = '0;

        // software reset paths
        bus_write(SFR_BASE | SFR_CTRL, 4'hf, 32'h1);
        model_sw_reset = 1'b1;
        model_irq_clear();
        check("ctrl write 1", 1, core_reset_o);
        bus_read("ctrl readback", SFR_BASE | SFR_CTRL, model_sfr_read(20'h04));
        bus_write(SFR_BASE | SFR_CTRL, 4'hf, 32'h0);
        model_sw_reset = 1'b0;
        check("ctrl write 0", 0, core_reset_o);
        sw_reset_set_i = 1'b1;
        @(negedge clk_i);
        check("set without enable", 0, core_reset_o);
        sw_reset_enb_i = 1'b1;
        @(negedge clk_i);
        sw_reset_set_i = 1'b0;
        check("set with enable", 1, core_reset_o);
        bus_write(SFR_BASE | SFR_CTRL, 4'hf, 32'h0);
        check("ctrl clear", 0, core_reset_o);
        sw_reset_autoclr_i = 1'b1;
        sw_reset_set_i     = 1'b1;
        @(negedge clk_i);
        sw_reset_set_i = 1'b0;
        check("autoclr first cycle", 1, core_reset_o);
        @(negedge clk_i);
        check("autoclr second cycle", 0, core_reset_o);
        sw_reset_autoclr_i = 1'b0;
        sw_reset_enb_i     = 1'b0;

        // line edges under a random mask
        for (int m = 0; m < 3; m++)
        begin
            data = take_bits(IRQ_NUM);
            bus_write(SFR_BASE | SFR_IRQ_EN, 4'hf, data);
            model_irq_en = data[IRQ_NUM-1:0];
            for (int p = 0; p < 6; p++)
            begin
                lines       = IRQ_NUM'(take_bits(IRQ_NUM));
                irq_lines_i = lines;
                @(negedge clk_i);
                model_line_update(lines);
                while (model_pending != '0)
                begin
                    wait_irq("line edge", TIMEOUT);
                    check("code enabled", 1, model_irq_en[irq_code_o]);
                    take_irq("line code");
                end
                check("lines idle", 0, irq_req_o);
                irq_lines_i = '0;
                @(negedge clk_i);
                model_line_update('0);
            end
        end

        // SGI ignores the mask
        bus_write(SFR_BASE | SFR_IRQ_EN, 4'hf, '0);
        model_irq_en = '0;
        for (int s = 0; s < 4; s++)
        begin
            code = IRQ_NUM_POW'(take_bits(IRQ_NUM_POW));
            data = (take_bits(32 - IRQ_NUM_POW) << IRQ_NUM_POW) | 32'(code);
            bus_write(SFR_BASE | SFR_SGI, 4'hf, data);
            model_pending[code] = 1'b1;
            wait_irq("sgi", TIMEOUT);
            check("sgi code", code, irq_code_o);
            take_irq("sgi ack");
        end
        check("sgi idle", 0, irq_req_o);

        // timer on line 1
        bus_write(SFR_BASE | SFR_IRQ_EN, 4'hf, 32'h1 << TIMER_IRQ_LINE);
        model_irq_en = IRQ_NUM'(1) << TIMER_IRQ_LINE;
        data = 32'd8 + take_bits(4);
        bus_write(SFR_BASE | SFR_TIMER_PERIOD, 4'hf, data);
        model_period = data;
        model_pending[TIMER_IRQ_LINE] = 1'b1;
        wait_irq("timer", 2 * int'(data) + TIMEOUT);
        take_irq("timer code");
        bus_write(SFR_BASE | SFR_TIMER_PERIOD, 4'hf, '0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sigma_tile.f
+incdir+tb
common/sigma_bus_pkg.sv
common/sigma_sfr_pkg.sv
logic/bus_decoder.sv
logic/data_ram.sv
sfr/sfr.sv
sfr/irq_adapter.sv
logic/sigma_tile.sv
tb/tb_sigma_tile.sv
